/* hdl/lc3b_types.sv */
package lc3b_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int offset_bits = 4;                  // 16-byte lines.
    localparam int index_bits  = 3;
    localparam int num_sets    = 1 << index_bits;    // 8 sets per way.
    localparam int tag_bits    = 16 - index_bits - offset_bits;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // CPU address and data word.
    typedef logic [15:0] lc3b_word;

    // Line-aligned address on the memory side.
    typedef logic [15:0] lc3b_pmem_addr;

    typedef logic [tag_bits-1:0] lc3b_cache_tag;

    typedef logic [index_bits-1:0] lc3b_set_index;

    // Eight words, word 0 in the low bits.
    typedef logic [127:0] lc3b_line;

endpackage : lc3b_types

/* hdl/cache_ctrl_if.sv */
`timescale 1ns/100ps

interface cache_ctrl_if import lc3b_types::*; ();

    // Controller to datapath.
    logic          load_way_one;   // Write way one this cycle.
    logic          load_way_two;   // Write way two this cycle.
    logic          store_word;     // CPU word, not memory line.
    logic          load_lru;

    // Datapath to controller.
    logic          hit;
    logic          hit_way_two;
    logic          lru;            // Set means way two is the victim.
    logic          victim_dirty;
    lc3b_cache_tag victim_tag;

    modport ctrl (
        output load_way_one, load_way_two, store_word, load_lru,
        input  hit, hit_way_two, lru, victim_dirty, victim_tag
    );

    modport dpath (
        input  load_way_one, load_way_two, store_word, load_lru,
        output hit, hit_way_two, lru, victim_dirty, victim_tag
    );

endinterface : cache_ctrl_if

/* hdl/cache_control.sv */
`timescale 1ns/100ps

module cache_control import lc3b_types::*; (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          mem_read,
    input  logic          mem_write,
    input  lc3b_word      mem_address,
    output logic          mem_resp,

    output logic          pmem_read,
    output logic          pmem_write,
    output lc3b_pmem_addr pmem_address,
    input  logic          pmem_resp,

    cache_ctrl_if.ctrl    ctl
);

    typedef enum logic [1:0] {
        hit_s,
        write_back_s,
        fetch_s,
        fill_s
    } control_state_t;

    control_state_t state;
    control_state_t next_state;

    logic          request;
    lc3b_pmem_addr fetch_addr;
    lc3b_pmem_addr victim_addr;

    assign request = mem_read | mem_write;

    assign fetch_addr  = {mem_address[15:offset_bits], {offset_bits{1'b0}}};
    assign victim_addr = {ctl.victim_tag, mem_address[offset_bits +: index_bits],
                          {offset_bits{1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        case (state)
            hit_s: begin
                if (request && !ctl.hit) begin
                    next_state = ctl.victim_dirty ? write_back_s : fetch_s;
                end
            end
            write_back_s: begin
                if (pmem_resp) begin
                    next_state = fetch_s;
                end
            end
            fetch_s: begin
                if (pmem_resp) begin
                    next_state = fill_s;
                end
            end
            fill_s:  next_state = hit_s;      // Request hits next cycle.
            default: next_state = hit_s;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        mem_resp         = 1'b0;
        pmem_read        = 1'b0;
        pmem_write       = 1'b0;
        pmem_address     = fetch_addr;
        ctl.load_way_one = 1'b0;
        ctl.load_way_two = 1'b0;
        ctl.store_word   = 1'b0;
        ctl.load_lru     = 1'b0;
        case (state)
            hit_s: begin
                if (request && ctl.hit) begin
                    mem_resp     = 1'b1;
                    ctl.load_lru = 1'b1;
                    if (mem_write) begin
                        ctl.store_word   = 1'b1;
                        ctl.load_way_one = ~ctl.hit_way_two;
                        ctl.load_way_two = ctl.hit_way_two;
                    end
                end
            end
            write_back_s: begin
                pmem_write   = 1'b1;
                pmem_address = victim_addr;
            end
            fetch_s: pmem_read = 1'b1;
            fill_s: begin
                ctl.load_way_one = ~ctl.lru;   // Replace the LRU way.
                ctl.load_way_two = ctl.lru;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= hit_s;
        end else begin
            state <= next_state;
        end
    end

endmodule : cache_control

/* hdl/cache_datapath.sv */
`timescale 1ns/100ps

module cache_datapath import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  lc3b_word   mem_address,
    input  lc3b_word   mem_wdata,
    output lc3b_word   mem_rdata,

    input  lc3b_line   pmem_rdata,
    output lc3b_line   pmem_wdata,

    cache_ctrl_if.dpath ctl
);

    // Way 0 is way one, way 1 is way two.
    lc3b_cache_tag tag_q  [2][num_sets];
    lc3b_line      data_q [2][num_sets];

    logic [1:0][num_sets-1:0] valid_q;
    logic [1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0]      lru_q;

    lc3b_cache_tag           addr_tag;
    lc3b_set_index           idx;
    logic [offset_bits-2:0]  word_sel;      // Word within the line.
    logic [1:0]              way_hit;
    logic [1:0]              load_way;
    logic                    victim_way;
    lc3b_line                hit_line;
    lc3b_line                store_line;
    lc3b_line                line_in;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address split and lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign addr_tag = mem_address[15 -: tag_bits];
    assign idx      = mem_address[offset_bits +: index_bits];
    assign word_sel = mem_address[offset_bits-1:1];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == addr_tag);
        end
    end

    assign ctl.hit         = |way_hit;
    assign ctl.hit_way_two = way_hit[1];

    // LRU bit names the way to replace.
    assign victim_way       = lru_q[idx];
    assign ctl.lru          = victim_way;
    assign ctl.victim_dirty = dirty_q[victim_way][idx];
    assign ctl.victim_tag   = tag_q[victim_way][idx];

    assign hit_line   = data_q[way_hit[1]][idx];
    assign mem_rdata  = hit_line[{word_sel, 4'h0} +: 16];
    assign pmem_wdata = data_q[victim_way][idx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign load_way = {ctl.load_way_two, ctl.load_way_one};

    always_comb begin
        store_line = data_q[ctl.load_way_two][idx];
        store_line[{word_sel, 4'h0} +: 16] = mem_wdata;    // Merge CPU word.
        line_in = ctl.store_word ? store_line : pmem_rdata;
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (load_way[w]) begin
                data_q[w][idx] <= line_in;
                tag_q[w][idx]  <= addr_tag;
            end
        end
    end

    // Valid, dirty and LRU state.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (load_way[w]) begin
                    valid_q[w][idx] <= 1'b1;
                    dirty_q[w][idx] <= ctl.store_word;    // Fill leaves it clean.
                end
            end
            if (ctl.load_lru) begin
                lru_q[idx] <= ~ctl.hit_way_two;           // Other way is now LRU.
            end
        end
    end

endmodule : cache_datapath

/* hdl/cache.sv */
`timescale 1ns/100ps

module cache import lc3b_types::*; (
    input  logic          clk,
    input  logic          rst_n,

    // CPU side.
    input  logic          mem_read,
    input  logic          mem_write,
    input  lc3b_word      mem_address,
    input  lc3b_word      mem_wdata,
    output lc3b_word      mem_rdata,
    output logic          mem_resp,

    // Physical memory side.
    output logic          pmem_read,
    output logic          pmem_write,
    output lc3b_pmem_addr pmem_address,
    output lc3b_line      pmem_wdata,
    input  lc3b_line      pmem_rdata,
    input  logic          pmem_resp
);

    cache_ctrl_if ctl_if ();

    cache_control control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_resp    (pmem_resp),
        .ctl          (ctl_if.ctrl)
    );

    cache_datapath datapath_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_wdata   (pmem_wdata),
        .ctl          (ctl_if.dpath)
    );

endmodule : cache

/* bench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 5;    // 10 ns clock.
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : clock_gen

/* bench/pmem_model.sv */
`timescale 1ns/100ps

module pmem_model import lc3b_types::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pmem_read,
    input  logic          pmem_write,
    input  lc3b_pmem_addr pmem_address,
    input  lc3b_line      pmem_wdata,
    output lc3b_line      pmem_rdata,
    output logic          pmem_resp,
    output int            read_count,
    output int            write_count,
    output lc3b_pmem_addr last_read_addr,
    output lc3b_pmem_addr last_write_addr,
    output lc3b_line      last_write_line
);

    localparam int          latency = 3;
    localparam logic [31:0] seed    = 32'ha092_dcf6;

    lc3b_line lines [4096];
    int       wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin : model
        logic [31:0] s;
        s = seed;
        for (int l = 0; l < 4096; l++) begin
            for (int j = 0; j < 8; j++) begin
                s = lcg_next(s);
                // Byte address mixed in.
                lines[12'(l)][j*16 +: 16] = s[31:16] ^ lc3b_word'(l*16 + j*2);
            end
        end
        pmem_rdata      <= '0;
        pmem_resp       <= 1'b0;
        read_count      <= 0;
        write_count     <= 0;
        last_read_addr  <= '0;
        last_write_addr <= '0;
        last_write_line <= '0;
        wait_cnt = 0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Strobe service with a one-cycle pmem_resp after the latency
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        forever begin
            @(posedge clk);
            if (!rst_n || pmem_resp) begin
                pmem_resp <= 1'b0;                 // Strobe drops this edge.
                wait_cnt = 0;
            end else if (pmem_read || pmem_write) begin
                if (wait_cnt == latency - 1) begin
                    wait_cnt = 0;
                    pmem_resp <= 1'b1;
                    if (pmem_write) begin
                        lines[pmem_address[15:4]] = pmem_wdata;
                        write_count     <= write_count + 1;
                        last_write_addr <= pmem_address;
                        last_write_line <= pmem_wdata;
                    end else begin
                        pmem_rdata     <= lines[pmem_address[15:4]];   // Held through fill.
                        read_count     <= read_count + 1;
                        last_read_addr <= pmem_address;
                    end
                end else begin
                    wait_cnt = wait_cnt + 1;
                end
            end
        end
    end

endmodule : pmem_model

/* bench/cache_tb.sv */
`timescale 1ns/100ps

module cache_tb import lc3b_types::*; ();

    localparam logic [31:0] seed    = 32'ha092_dcf6;
    localparam int          timeout = 200;

    logic          clk;
    logic          rst_n;
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_address;
    lc3b_word      mem_wdata;
    lc3b_word      mem_rdata;
    logic          mem_resp;
    logic          pmem_read;
    logic          pmem_write;
    lc3b_pmem_addr pmem_address;
    lc3b_line      pmem_wdata;
    lc3b_line      pmem_rdata;
    logic          pmem_resp;
    int            read_count;
    int            write_count;
    lc3b_pmem_addr last_read_addr;
    lc3b_pmem_addr last_write_addr;
    lc3b_line      last_write_line;

    lc3b_word      ref_words [32768];     // Flat image of memory as the CPU sees it.
    logic [31:0]   rand_state;

    clock_gen  clock_i (.clk(clk), .rst_n(rst_n));
    cache      dut_i (.*);
    pmem_model pmem_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic lc3b_word expected_read(input lc3b_word addr);
        return ref_words[addr[15:1]];
    endfunction

    function automatic lc3b_line expected_line(input lc3b_pmem_addr addr);
        lc3b_line line;
        for (int j = 0; j < 8; j++) begin
            line[j*16 +: 16] = ref_words[{addr[15:4], 3'(j)}];
        end
        return line;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input lc3b_word exp, input lc3b_word got);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got));
        end
    endtask

    task automatic check_addr(input string what, input lc3b_pmem_addr exp,
                              input lc3b_pmem_addr got);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int got);
        if (got != exp) begin
            fail_run($sformatf("mismatch at %0t: %s, expected %0d, got %0d", $time, what, exp, got));
        end
    endtask

    task automatic check_traffic(input string what, input int rd0, input int wr0,
                                 input int rd_exp, input int wr_exp);
        check_count({what, " pmem reads"}, rd_exp, read_count - rd0);
        check_count({what, " pmem writes"}, wr_exp, write_count - wr0);
    endtask

    // One CPU request held until mem_resp.
    task automatic cpu_access(input logic write, input lc3b_word addr, input lc3b_word data,
                              output lc3b_word rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        mem_read    <= !write;
        mem_write   <= write;
        mem_address <= addr;
        mem_wdata   <= data;
        @(negedge clk);
        while (!mem_resp) begin
            cycles++;
            if (cycles >= timeout) begin
                fail_run($sformatf("no mem_resp for address %h within %0d cycles", addr, timeout));
            end
            @(negedge clk);
        end
        rdata = mem_rdata;
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    // Writes update the reference image and reads are checked against it.
    initial begin : monitor
        logic [31:0] s;
        s = seed;
        for (int i = 0; i < 32768; i++) begin
            s = lcg_next(s);
            ref_words[15'(i)] = s[31:16] ^ lc3b_word'(i * 2);
        end
        forever begin
            @(negedge clk);
            if (rst_n && mem_resp && mem_write) begin
                ref_words[mem_address[15:1]] = mem_wdata;
            end else if (rst_n && mem_resp) begin
                check_word("read data", expected_read(mem_address), mem_rdata);
            end
        end
    end

    initial begin : stimulus
        lc3b_word data;
        lc3b_word addr;
        lc3b_line line_exp;
        logic     write;
        int       rd0;
        int       wr0;
        int       cycles;
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        mem_address <= '0;
        mem_wdata   <= '0;
        rand_state = seed;

        // Strobes stay low through reset and the first cycle after.
        @(posedge clk);
        cycles = 0;
        while (!rst_n) begin
            @(negedge clk);
            check_word("strobes around reset", 16'h0, {13'b0, mem_resp, pmem_read, pmem_write});
            cycles++;
            if (cycles >= timeout) begin
                fail_run("reset was never released");
            end
        end
        @(negedge clk);
        check_word("strobes after reset", 16'h0, {13'b0, mem_resp, pmem_read, pmem_write});

        rd0 = read_count;
        wr0 = write_count;
        cpu_access(1'b0, 16'h1234, '0, data);             // Read miss.
        check_traffic("read miss", rd0, wr0, 1, 0);
        check_addr("fetch address", 16'h1230, last_read_addr);
        cpu_access(1'b0, 16'h1230, '0, data);
        cpu_access(1'b0, 16'h123e, '0, data);
        cpu_access(1'b1, 16'h1236, 16'hbeef, data);       // Write hit.
        cpu_access(1'b0, 16'h1236, '0, data);
        check_word("read after write hit", 16'hbeef, data);
        check_traffic("hits", rd0, wr0, 1, 0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Dirty line eviction with three tags in set 3
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        cpu_access(1'b1, 16'h123a, 16'h5a5a, data);
        cpu_access(1'b0, 16'h2234, '0, data);             // Fills the other way.
        rd0 = read_count;
        wr0 = write_count;
        cpu_access(1'b0, 16'h3234, '0, data);
        check_traffic("eviction", rd0, wr0, 1, 1);
        check_addr("write-back address", 16'h1230, last_write_addr);
        check_word("written-back word", 16'h5a5a, last_write_line[5*16 +: 16]);
        line_exp = expected_line(16'h1230);
        for (int j = 0; j < 8; j++) begin
            check_word("written-back line", line_exp[j*16 +: 16], last_write_line[j*16 +: 16]);
        end
        cpu_access(1'b0, 16'h123a, '0, data);
        check_word("re-read of evicted word", 16'h5a5a, data);

        // Write miss allocates and the whole line reads back.
        rd0 = read_count;
        wr0 = write_count;
        cpu_access(1'b1, 16'h4a52, 16'h1357, data);
        check_traffic("write miss", rd0, wr0, 1, 0);
        check_addr("write miss fetch address", 16'h4a50, last_read_addr);
        cpu_access(1'b0, 16'h4a52, '0, data);
        check_word("read after write miss", 16'h1357, data);
        for (int j = 0; j < 8; j++) begin
            cpu_access(1'b0, lc3b_word'(16'h4a50 + 2*j), '0, data);
        end
        check_traffic("allocated line reads", rd0, wr0, 1, 0);

        // Random reads and writes over 64 lines in all sets.
        for (int n = 0; n < 500; n++) begin
            rand_state = lcg_next(rand_state);
            write = rand_state[28];
            addr  = {4'h6, 2'b00, rand_state[24:19], rand_state[18:16], 1'b0};
            rand_state = lcg_next(rand_state);
            cpu_access(write, addr, rand_state[31:16], data);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : cache_tb

/* verilog.f */
hdl/lc3b_types.sv
hdl/cache_ctrl_if.sv
hdl/cache_control.sv
hdl/cache_datapath.sv
hdl/cache.sv
bench/clock_gen.sv
bench/pmem_model.sv
bench/cache_tb.sv

/* Makefile */
# Verilator flow for the cache and its testbench.

TOP       ?= cache_tb
RTL_TOP   ?= cache
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing -f verilog.f
RTL_SRC   ?= $(shell grep '^hdl/' verilog.f)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRC)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
